// ==== rtl/cache_pkg.sv ====
// shared widths, typedefs and geometry for the split L1 caches
// every cache RTL module takes what it needs from here

package cache_pkg;

  // basic widths
  localparam int WORD_W     = 32;
  localparam int BYTE_OFF_W = 2;  // byte offset inside a word
  localparam int NUM_BYTES  = WORD_W / 8;

  // cache geometry, one word per line
  localparam int NUM_LINES = 32;
  localparam int INDEX_W   = $clog2(NUM_LINES);          // word-address bits 6:2
  localparam int TAG_W     = WORD_W - INDEX_W - BYTE_OFF_W; // 25 bits

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [WORD_W-1:0]    addr_t;  // byte address, low bits ignored
  typedef logic [NUM_BYTES-1:0] byte_en_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [INDEX_W-1:0]   index_t;

  // everything from here up goes straight to memory
  localparam addr_t NONCACHE_START_ADDR = 32'h8000_0000;

  typedef enum logic [2:0] {
    IDLE,        // serving hits, launching misses
    WRITEBACK,   // dirty victim going out
    FILL,        // line coming in
    UNCACHED,    // single bypass access
    FLUSH_SCAN,  // look at one line of the walk
    FLUSH_WB,    // write back a dirty line found by the walk
    FLUSH_DONE   // walk finished, wait for flush to drop
  } cache_state_t;

endpackage

// ==== rtl/dm_cache.sv ====
// direct-mapped write-back cache, one word per line, byte-enabled writes
// processor generic bus on one side, memory generic bus on the other
`timescale 1ns/1ps

module dm_cache (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                flush,
  input  cache_pkg::addr_t    proc_addr,
  input  cache_pkg::word_t    proc_wdata,
  input  logic                proc_ren,
  input  logic                proc_wen,
  input  cache_pkg::byte_en_t proc_byte_en,
  output cache_pkg::word_t    proc_rdata,
  output logic                proc_busy,
  output cache_pkg::addr_t    mem_addr,
  output cache_pkg::word_t    mem_wdata,
  output logic                mem_ren,
  output logic                mem_wen,
  input  cache_pkg::word_t    mem_rdata,
  input  logic                mem_busy,
  output logic                flush_done
);
  import cache_pkg::*;

  // line storage
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;
  tag_t                 tags [NUM_LINES];
  word_t                data [NUM_LINES];

  cache_state_t state, next_state;
  index_t       flush_idx;  // walk position
  logic         uc_done;    // bypass access finished, result waiting
  word_t        uc_rdata;

  index_t idx;
  tag_t   tag;
  logic   req;
  logic   noncache;
  logic   hit;
  logic   victim_dirty;
  logic   walk_dirty;
  logic   flush_last;
  logic   complete;

  assign idx          = proc_addr[BYTE_OFF_W +: INDEX_W];
  assign tag          = proc_addr[BYTE_OFF_W+INDEX_W +: TAG_W];
  assign req          = proc_ren | proc_wen;
  assign noncache     = (proc_addr >= NONCACHE_START_ADDR);
  assign hit          = valid[idx] && (tags[idx] == tag);
  assign victim_dirty = valid[idx] & dirty[idx];
  assign walk_dirty   = valid[flush_idx] & dirty[flush_idx];
  assign flush_last   = (flush_idx == index_t'(NUM_LINES - 1));

  // processor access finishes this cycle
  assign complete = (state == IDLE) && !flush && req && (noncache ? uc_done : hit);

  assign proc_busy  = !((state == IDLE) && !flush && (!req || complete));
  assign proc_rdata = noncache ? uc_rdata : data[idx];
  assign flush_done = (state == FLUSH_DONE);

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (flush) begin
          next_state = FLUSH_SCAN;
        end else if (req && noncache && !uc_done) begin
          next_state = UNCACHED;
        end else if (req && !noncache && !hit) begin
          next_state = victim_dirty ? WRITEBACK : FILL;
        end
      end
      WRITEBACK:  if (!mem_busy) next_state = FILL;
      FILL:       if (!mem_busy) next_state = IDLE;  // retried as a hit next cycle
      UNCACHED:   if (!mem_busy) next_state = IDLE;
      FLUSH_SCAN: begin
        if (walk_dirty) begin
          next_state = FLUSH_WB;
        end else if (flush_last) begin
          next_state = FLUSH_DONE;
        end
      end
      FLUSH_WB:   if (!mem_busy) next_state = FLUSH_SCAN;  // line now clean
      FLUSH_DONE: if (!flush) next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  // memory side requests come from the state alone
  always_comb begin
    mem_addr  = {proc_addr[WORD_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
    mem_wdata = proc_wdata;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    unique case (state)
      WRITEBACK: begin
        mem_addr  = {tags[idx], idx, {BYTE_OFF_W{1'b0}}};  // victim address
        mem_wdata = data[idx];
        mem_wen   = 1'b1;
      end
      FILL: begin
        mem_ren = 1'b1;
      end
      UNCACHED: begin
        // no byte enables toward memory, whole word goes out
        mem_ren = proc_ren;
        mem_wen = proc_wen;
      end
      FLUSH_WB: begin
        mem_addr  = {tags[flush_idx], flush_idx, {BYTE_OFF_W{1'b0}}};
        mem_wdata = data[flush_idx];
        mem_wen   = 1'b1;
      end
      default: ;
    endcase
  end

  // control state and line status bits
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      valid     <= '0;
      dirty     <= '0;
      flush_idx <= '0;
      uc_done   <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        IDLE: begin
          if (complete && noncache) uc_done <= 1'b0;  // result handed over
          if (complete && !noncache && proc_wen) dirty[idx] <= 1'b1;
          if (flush) flush_idx <= '0;  // walk starts at line 0
        end
        FILL: begin
          if (!mem_busy) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= 1'b0;
          end
        end
        UNCACHED: if (!mem_busy) uc_done <= 1'b1;
        FLUSH_SCAN: begin
          if (!walk_dirty) begin
            valid[flush_idx] <= 1'b0;
            if (!flush_last) flush_idx <= flush_idx + 1'b1;
          end
        end
        FLUSH_WB: if (!mem_busy) dirty[flush_idx] <= 1'b0;
        default: ;
      endcase
    end
  end

  // tags, data and the bypass read word
  always_ff @(posedge CLK) begin
    if (state == FILL && !mem_busy) begin
      tags[idx] <= tag;
      data[idx] <= mem_rdata;
    end
    if (complete && !noncache && proc_wen) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (proc_byte_en[b]) data[idx][8*b +: 8] <= proc_wdata[8*b +: 8];  // merge
      end
    end
    if (state == UNCACHED && !mem_busy) uc_rdata <= mem_rdata;
  end

endmodule

// ==== rtl/separate_caches.sv ====
// split instruction and data caches with their flush control
// flush requests drop once a cache reports done, done is held while requested
`timescale 1ns/1ps

module separate_caches (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                halt_flush,
  input  logic                flushing_icache,
  input  logic                flushing_dcache,
  // icache processor bus
  input  cache_pkg::addr_t    icache_proc_addr,
  input  cache_pkg::word_t    icache_proc_wdata,
  input  logic                icache_proc_ren,
  input  logic                icache_proc_wen,
  input  cache_pkg::byte_en_t icache_proc_byte_en,
  output cache_pkg::word_t    icache_proc_rdata,
  output logic                icache_proc_busy,
  // dcache processor bus
  input  cache_pkg::addr_t    dcache_proc_addr,
  input  cache_pkg::word_t    dcache_proc_wdata,
  input  logic                dcache_proc_ren,
  input  logic                dcache_proc_wen,
  input  cache_pkg::byte_en_t dcache_proc_byte_en,
  output cache_pkg::word_t    dcache_proc_rdata,
  output logic                dcache_proc_busy,
  // icache memory bus
  output cache_pkg::addr_t    icache_mem_addr,
  output cache_pkg::word_t    icache_mem_wdata,
  output logic                icache_mem_ren,
  output logic                icache_mem_wen,
  input  cache_pkg::word_t    icache_mem_rdata,
  input  logic                icache_mem_busy,
  // dcache memory bus
  output cache_pkg::addr_t    dcache_mem_addr,
  output cache_pkg::word_t    dcache_mem_wdata,
  output logic                dcache_mem_ren,
  output logic                dcache_mem_wen,
  input  cache_pkg::word_t    dcache_mem_rdata,
  input  logic                dcache_mem_busy,
  output logic                iflush_done,
  output logic                dflush_done
);

  logic [1:0] flush_req;   // bit 0 icache, bit 1 dcache
  logic [1:0] cache_done;  // straight from the caches
  logic [1:0] done_held;   // done seen earlier in this request
  logic       icache_flush;
  logic       dcache_flush;

  assign flush_req = {halt_flush | flushing_dcache, flushing_icache};

  // cache leaves FLUSH_DONE as soon as its flush drops, so keep the flag here
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      done_held <= '0;
    end else begin
      done_held <= flush_req & (done_held | cache_done);
    end
  end

  assign {dflush_done, iflush_done} = flush_req & (done_held | cache_done);

  assign dcache_flush = flush_req[1] & ~dflush_done;
  assign icache_flush = flush_req[0] & ~iflush_done;

  dm_cache icache (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .flush        (icache_flush),
    .proc_addr    (icache_proc_addr),
    .proc_wdata   (icache_proc_wdata),
    .proc_ren     (icache_proc_ren),
    .proc_wen     (icache_proc_wen),
    .proc_byte_en (icache_proc_byte_en),
    .proc_rdata   (icache_proc_rdata),
    .proc_busy    (icache_proc_busy),
    .mem_addr     (icache_mem_addr),
    .mem_wdata    (icache_mem_wdata),
    .mem_ren      (icache_mem_ren),
    .mem_wen      (icache_mem_wen),
    .mem_rdata    (icache_mem_rdata),
    .mem_busy     (icache_mem_busy),
    .flush_done   (cache_done[0])
  );

  dm_cache dcache (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .flush        (dcache_flush),
    .proc_addr    (dcache_proc_addr),
    .proc_wdata   (dcache_proc_wdata),
    .proc_ren     (dcache_proc_ren),
    .proc_wen     (dcache_proc_wen),
    .proc_byte_en (dcache_proc_byte_en),
    .proc_rdata   (dcache_proc_rdata),
    .proc_busy    (dcache_proc_busy),
    .mem_addr     (dcache_mem_addr),
    .mem_wdata    (dcache_mem_wdata),
    .mem_ren      (dcache_mem_ren),
    .mem_wen      (dcache_mem_wen),
    .mem_rdata    (dcache_mem_rdata),
    .mem_busy     (dcache_mem_busy),
    .flush_done   (cache_done[1])
  );

endmodule

// ==== rtl/mem_arbiter.sv ====
// merges the icache and dcache memory buses onto one memory port
// dcache wins a tie, the grant is held until the granted access completes
`timescale 1ns/1ps

module mem_arbiter (
  input  logic             CLK,
  input  logic             arst_n,
  // icache side
  input  cache_pkg::addr_t icache_addr,
  input  cache_pkg::word_t icache_wdata,
  input  logic             icache_ren,
  input  logic             icache_wen,
  output cache_pkg::word_t icache_rdata,
  output logic             icache_busy,
  // dcache side
  input  cache_pkg::addr_t dcache_addr,
  input  cache_pkg::word_t dcache_wdata,
  input  logic             dcache_ren,
  input  logic             dcache_wen,
  output cache_pkg::word_t dcache_rdata,
  output logic             dcache_busy,
  // memory port
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::word_t mem_wdata,
  output logic             mem_ren,
  output logic             mem_wen,
  input  cache_pkg::word_t mem_rdata,
  input  logic             mem_busy
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_ICACHE,
    OWN_DCACHE
  } owner_t;

  owner_t owner;  // registered owner of an access in flight
  owner_t grant;  // owner for this cycle
  logic   icache_req;
  logic   dcache_req;

  assign icache_req = icache_ren | icache_wen;
  assign dcache_req = dcache_ren | dcache_wen;

  // pick in the idle cycle, dcache first
  always_comb begin
    grant = owner;
    if (owner == OWN_NONE) begin
      if (dcache_req) begin
        grant = OWN_DCACHE;
      end else if (icache_req) begin
        grant = OWN_ICACHE;
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      owner <= OWN_NONE;
    end else if (grant != OWN_NONE && !mem_busy) begin
      owner <= OWN_NONE;  // access done, free for next cycle
    end else begin
      owner <= grant;
    end
  end

  always_comb begin
    mem_addr    = dcache_addr;
    mem_wdata   = dcache_wdata;
    mem_ren     = 1'b0;
    mem_wen     = 1'b0;
    icache_busy = 1'b1;  // loser always sees busy
    dcache_busy = 1'b1;
    case (grant)
      OWN_DCACHE: begin
        mem_ren     = dcache_ren;
        mem_wen     = dcache_wen;
        dcache_busy = mem_busy;
      end
      OWN_ICACHE: begin
        mem_addr    = icache_addr;
        mem_wdata   = icache_wdata;
        mem_ren     = icache_ren;
        mem_wen     = icache_wen;
        icache_busy = mem_busy;
      end
      default: ;
    endcase
  end

  // only valid for whoever sees busy low
  assign icache_rdata = mem_rdata;
  assign dcache_rdata = mem_rdata;

endmodule

// ==== rtl/cache_subsystem.sv ====
// top of the L1 cache subsystem, split caches in front of one memory port
// processor fetch and data buses in, shared memory bus out
`timescale 1ns/1ps

module cache_subsystem (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                halt_flush,
  input  logic                flushing_icache,
  input  logic                flushing_dcache,
  // instruction fetch bus
  input  cache_pkg::addr_t    icache_proc_addr,
  input  cache_pkg::word_t    icache_proc_wdata,
  input  logic                icache_proc_ren,
  input  logic                icache_proc_wen,
  input  cache_pkg::byte_en_t icache_proc_byte_en,
  output cache_pkg::word_t    icache_proc_rdata,
  output logic                icache_proc_busy,
  // data bus
  input  cache_pkg::addr_t    dcache_proc_addr,
  input  cache_pkg::word_t    dcache_proc_wdata,
  input  logic                dcache_proc_ren,
  input  logic                dcache_proc_wen,
  input  cache_pkg::byte_en_t dcache_proc_byte_en,
  output cache_pkg::word_t    dcache_proc_rdata,
  output logic                dcache_proc_busy,
  // external memory
  output cache_pkg::addr_t    mem_addr,
  output cache_pkg::word_t    mem_wdata,
  output logic                mem_ren,
  output logic                mem_wen,
  input  cache_pkg::word_t    mem_rdata,
  input  logic                mem_busy,
  output logic                iflush_done,
  output logic                dflush_done
);

  // cache to arbiter buses
  cache_pkg::addr_t icache_mem_addr, dcache_mem_addr;
  cache_pkg::word_t icache_mem_wdata, dcache_mem_wdata;
  cache_pkg::word_t icache_mem_rdata, dcache_mem_rdata;
  logic             icache_mem_ren, icache_mem_wen, icache_mem_busy;
  logic             dcache_mem_ren, dcache_mem_wen, dcache_mem_busy;

  separate_caches caches (
    .CLK                 (CLK),
    .arst_n              (arst_n),
    .halt_flush          (halt_flush),
    .flushing_icache     (flushing_icache),
    .flushing_dcache     (flushing_dcache),
    .icache_proc_addr    (icache_proc_addr),
    .icache_proc_wdata   (icache_proc_wdata),
    .icache_proc_ren     (icache_proc_ren),
    .icache_proc_wen     (icache_proc_wen),
    .icache_proc_byte_en (icache_proc_byte_en),
    .icache_proc_rdata   (icache_proc_rdata),
    .icache_proc_busy    (icache_proc_busy),
    .dcache_proc_addr    (dcache_proc_addr),
    .dcache_proc_wdata   (dcache_proc_wdata),
    .dcache_proc_ren     (dcache_proc_ren),
    .dcache_proc_wen     (dcache_proc_wen),
    .dcache_proc_byte_en (dcache_proc_byte_en),
    .dcache_proc_rdata   (dcache_proc_rdata),
    .dcache_proc_busy    (dcache_proc_busy),
    .icache_mem_addr     (icache_mem_addr),
    .icache_mem_wdata    (icache_mem_wdata),
    .icache_mem_ren      (icache_mem_ren),
    .icache_mem_wen      (icache_mem_wen),
    .icache_mem_rdata    (icache_mem_rdata),
    .icache_mem_busy     (icache_mem_busy),
    .dcache_mem_addr     (dcache_mem_addr),
    .dcache_mem_wdata    (dcache_mem_wdata),
    .dcache_mem_ren      (dcache_mem_ren),
    .dcache_mem_wen      (dcache_mem_wen),
    .dcache_mem_rdata    (dcache_mem_rdata),
    .dcache_mem_busy     (dcache_mem_busy),
    .iflush_done         (iflush_done),
    .dflush_done         (dflush_done)
  );

  mem_arbiter arbiter (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .icache_addr  (icache_mem_addr),
    .icache_wdata (icache_mem_wdata),
    .icache_ren   (icache_mem_ren),
    .icache_wen   (icache_mem_wen),
    .icache_rdata (icache_mem_rdata),
    .icache_busy  (icache_mem_busy),
    .dcache_addr  (dcache_mem_addr),
    .dcache_wdata (dcache_mem_wdata),
    .dcache_ren   (dcache_mem_ren),
    .dcache_wen   (dcache_mem_wen),
    .dcache_rdata (dcache_mem_rdata),
    .dcache_busy  (dcache_mem_busy),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .mem_rdata    (mem_rdata),
    .mem_busy     (mem_busy)
  );

endmodule

// ==== tb/cache_asserts.sv ====
// bus protocol and flush checks, bound into every dm_cache instance
// the testbench reads fail_count at the end of the run
`timescale 1ns/1ps

module cache_asserts (
  input logic CLK,
  input logic arst_n,
  input logic flush,
  input logic flush_done,
  input logic proc_ren,
  input logic proc_wen,
  input logic mem_ren,
  input logic mem_wen
);

  int unsigned fail_count = 0;

  // never read and write at once
  proc_excl: assert property (@(posedge CLK) disable iff (!arst_n) !(proc_ren && proc_wen))
    else begin
      fail_count++;
      $error("processor bus has ren and wen high together");
    end

  mem_excl: assert property (@(posedge CLK) disable iff (!arst_n) !(mem_ren && mem_wen))
    else begin
      fail_count++;
      $error("memory bus has ren and wen high together");
    end

  // quiet memory side during reset
  mem_reset: assert property (@(posedge CLK) !arst_n |-> (!mem_ren && !mem_wen))
    else begin
      fail_count++;
      $error("memory request raised while in reset");
    end

  // back to idle once the flush request is released
  flush_release: assert property (@(posedge CLK) disable iff (!arst_n)
                                  (flush_done && !flush) |=> !flush_done)
    else begin
      fail_count++;
      $error("flush_done still high a cycle after flush dropped");
    end

endmodule

bind dm_cache cache_asserts proto_chk (.*);

// ==== tb/tb_cache_subsystem.sv ====
// testbench for the split L1 cache subsystem
// drives both processor buses, models the external memory and checks reads against a shadow copy
`timescale 1ns/1ps

module tb_cache_subsystem;
  import cache_pkg::*;

  localparam int MEM_WORDS      = 1024;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int PAIRS          = 24;  // concurrent icache/dcache accesses

  logic     CLK;
  logic     arst_n;
  logic     halt_flush;
  logic     flushing_icache;
  logic     flushing_dcache;
  addr_t    icache_proc_addr, dcache_proc_addr;
  word_t    icache_proc_wdata, dcache_proc_wdata;
  logic     icache_proc_ren, icache_proc_wen;
  logic     dcache_proc_ren, dcache_proc_wen;
  byte_en_t icache_proc_byte_en, dcache_proc_byte_en;
  word_t    icache_proc_rdata, dcache_proc_rdata;
  logic     icache_proc_busy, dcache_proc_busy;
  addr_t    mem_addr;
  word_t    mem_wdata, mem_rdata;
  logic     mem_ren, mem_wen, mem_busy;
  logic     iflush_done, dflush_done;

  word_t       mem_model [MEM_WORDS];
  word_t       shadow [MEM_WORDS];   // what memory must hold once all caches are flushed
  bit          written [MEM_WORDS];
  logic [1:0]  wait_cnt;
  int unsigned nc_writes;            // completed writes above the uncached start
  addr_t       nc_last_addr;
  int unsigned cycles;

  cache_subsystem uut (.*);

  always #20 CLK = ~CLK;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // expected read data, straight from the shadow image
  function automatic word_t expected_word(addr_t a);
    return shadow[a[11:2]];
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  // memory: two busy cycles, then the access completes
  assign mem_busy  = (mem_ren | mem_wen) && (wait_cnt != 2'd2);
  assign mem_rdata = mem_model[mem_addr[11:2]];

  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
    end else if (mem_ren | mem_wen) begin
      if (mem_busy) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0;
        if (mem_wen) begin
          mem_model[mem_addr[11:2]] = mem_wdata;
          if (mem_addr >= NONCACHE_START_ADDR) begin
            nc_writes    = nc_writes + 1;
            nc_last_addr = mem_addr;
          end
        end
      end
    end
  end

  // compare completed reads, mirror completed writes
  always @(posedge CLK) begin : compare
    word_t exp_w;
    if (arst_n) begin
      if (dcache_proc_ren && !dcache_proc_busy) begin
        exp_w = expected_word(dcache_proc_addr);
        assert (dcache_proc_rdata === exp_w)
          else fail_now($sformatf("[ERROR] %0t ns dcache read %h expected %h got %h",
                                  $time, dcache_proc_addr, exp_w, dcache_proc_rdata));
      end
      if (icache_proc_ren && !icache_proc_busy) begin
        exp_w = expected_word(icache_proc_addr);
        assert (icache_proc_rdata === exp_w)
          else fail_now($sformatf("[ERROR] %0t ns icache read %h expected %h got %h",
                                  $time, icache_proc_addr, exp_w, icache_proc_rdata));
      end
      if (dcache_proc_wen && !dcache_proc_busy) begin
        shadow[dcache_proc_addr[11:2]] = merge_bytes(shadow[dcache_proc_addr[11:2]],
                                                     dcache_proc_wdata, dcache_proc_byte_en);
        written[dcache_proc_addr[11:2]] = 1'b1;
      end
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles == TIMEOUT_CYCLES) fail_now("timeout: the tests did not finish in time");
  end

  // one data access, held until busy drops, request released afterwards
  task automatic dcache_access(input logic write, input addr_t a, input word_t d,
                               input byte_en_t be, output int unsigned nc_at_done);
    @(negedge CLK);
    dcache_proc_addr    = a;
    dcache_proc_wdata   = d;
    dcache_proc_byte_en = be;
    dcache_proc_ren     = !write;
    dcache_proc_wen     = write;
    #10;
    while (dcache_proc_busy) begin
      @(negedge CLK);
      #10;
    end
    nc_at_done = nc_writes;  // completes at the coming edge
    @(negedge CLK);
    dcache_proc_ren = 1'b0;
    dcache_proc_wen = 1'b0;
  endtask

  task automatic icache_fetch(input addr_t a);
    @(negedge CLK);
    icache_proc_addr = a;
    icache_proc_ren  = 1'b1;
    #10;
    while (icache_proc_busy) begin
      @(negedge CLK);
      #10;
    end
    @(negedge CLK);
    icache_proc_ren = 1'b0;
  endtask

  initial begin : stimulus
    int unsigned w, w2;
    int unsigned nc_before, nc_done;
    addr_t       nc_addr;
    addr_t       i_addr [PAIRS];
    addr_t       d_addr [PAIRS];
    word_t       d_wdat [PAIRS];
    void'($urandom(66172));
    CLK = 1'b0;
    arst_n = 1'b0;
    halt_flush = 1'b0;
    flushing_icache = 1'b0;
    flushing_dcache = 1'b0;
    icache_proc_addr = '0;
    icache_proc_wdata = '0;
    icache_proc_ren = 1'b0;
    icache_proc_wen = 1'b0;
    icache_proc_byte_en = '0;
    dcache_proc_addr = '0;
    dcache_proc_wdata = '0;
    dcache_proc_ren = 1'b0;
    dcache_proc_wen = 1'b0;
    dcache_proc_byte_en = '0;
    nc_writes = 0;
    nc_last_addr = '0;
    cycles = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = $urandom;
      shadow[i]    = mem_model[i];
      written[i]   = 1'b0;
    end
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;

    // write, hit, conflicting read evicts the dirty line, read back
    for (int i = 0; i < 96; i++) begin
      w  = $urandom_range(0, 255);
      w2 = (w + 32 * $urandom_range(1, 7)) % 256;  // same index, other tag
      dcache_access(1'b1, addr_t'(w * 4), $urandom, 4'hF, nc_done);
      dcache_access(1'b0, addr_t'(w * 4), '0, 4'hF, nc_done);
      dcache_access(1'b0, addr_t'(w2 * 4), '0, 4'hF, nc_done);
      dcache_access(1'b0, addr_t'(w * 4), '0, 4'hF, nc_done);
    end

    // partial byte masks
    for (int i = 0; i < 32; i++) begin
      w = $urandom_range(0, 255);
      dcache_access(1'b1, addr_t'(w * 4), $urandom, byte_en_t'($urandom_range(1, 14)), nc_done);
      dcache_access(1'b0, addr_t'(w * 4), '0, 4'hF, nc_done);
    end

    // uncached region, words 512 and up so it never aliases cached data
    for (int i = 0; i < 8; i++) begin
      nc_addr   = NONCACHE_START_ADDR | addr_t'((512 + $urandom_range(0, 511)) * 4);
      nc_before = nc_writes;
      dcache_access(1'b1, nc_addr, $urandom, 4'hF, nc_done);
      assert (nc_done == nc_before + 1 && nc_last_addr == nc_addr)
        else fail_now($sformatf("[ERROR] %0t ns uncached write %h seen %0d times, last %h",
                                $time, nc_addr, nc_done - nc_before, nc_last_addr));
      dcache_access(1'b0, nc_addr, '0, 4'hF, nc_done);
      nc_addr = NONCACHE_START_ADDR | addr_t'((512 + $urandom_range(0, 511)) * 4);
      dcache_access(1'b0, nc_addr, '0, 4'hF, nc_done);
    end

    // both caches miss together, fetches stay clear of data-written words
    for (int i = 0; i < PAIRS; i++) begin
      i_addr[i] = addr_t'((256 + $urandom_range(0, 255)) * 4);
      d_addr[i] = addr_t'($urandom_range(0, 255) * 4);
      d_wdat[i] = $urandom;
    end
    fork
      for (int i = 0; i < PAIRS; i++) icache_fetch(i_addr[i]);
      for (int i = 0; i < PAIRS; i++) dcache_access(1'(i % 2), d_addr[i], d_wdat[i], 4'hF, nc_done);
    join

    // data cache first, then instruction cache
    @(negedge CLK);
    halt_flush = 1'b1;
    #10;
    while (!dflush_done) begin
      @(negedge CLK);
      #10;
    end
    @(negedge CLK);
    halt_flush = 1'b0;
    flushing_icache = 1'b1;
    #10;
    while (!iflush_done) begin
      @(negedge CLK);
      #10;
    end
    @(negedge CLK);
    flushing_icache = 1'b0;

    for (int i = 0; i < MEM_WORDS; i++) begin
      if (written[i]) begin
        assert (mem_model[i] === shadow[i])
          else fail_now($sformatf("[ERROR] %0t ns memory word %0d expected %h got %h",
                                  $time, i, shadow[i], mem_model[i]));
      end
    end
    for (int i = 0; i < 256; i++) begin
      if (written[i]) icache_fetch(addr_t'(i * 4));  // new code seen by fetch
    end

    repeat (4) @(negedge CLK);
    if (uut.caches.icache.proto_chk.fail_count == 0 &&
        uut.caches.dcache.proto_chk.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_now("bound protocol assertions reported errors in a cache");
    end
  end

endmodule

// ==== tb.f ====
rtl/cache_pkg.sv
rtl/dm_cache.sv
rtl/separate_caches.sv
rtl/mem_arbiter.sv
rtl/cache_subsystem.sv
tb/cache_asserts.sv
tb/tb_cache_subsystem.sv

// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - rtl/cache_pkg.sv
  - rtl/dm_cache.sv
  - rtl/separate_caches.sv
  - rtl/mem_arbiter.sv
  - rtl/cache_subsystem.sv
  - target: simulation
    files:
      - tb/cache_asserts.sv
      - tb/tb_cache_subsystem.sv
